// File: src.f
source/l2cache_pkg.sv
source/l2cache_req_buf.sv
source/l2cache_tagv.sv
source/l2cache_data.sv
source/l2cache_plru.sv
source/l2cache_fsm.sv
source/l2cache.sv
sim/l2cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing -Wno-fatal --top-module l2cache_tb -f src.f -o l2cache_sim
./obj_dir/l2cache_sim | tee "$log"

if grep -qx "Simulation passed" "$log"; then
    exit 0
fi
exit 1

// File: sim/l2cache_tb.sv
`timescale 1ns/1ps

module l2cache_tb;

    localparam int index_width  = 2;
    localparam int offset_width = 2;
    localparam int line_width   = 32 << offset_width;
    localparam int words        = 1 << offset_width;
    localparam int timeout      = 200;
    localparam int sel_i_addr   = 0;
    localparam int sel_i_data   = 1;
    localparam int sel_d_addr   = 2;
    localparam int sel_d_data   = 3;
    // Fetches and data accesses use disjoint regions
    localparam logic [31:0] i_base = 32'h0004_0000;
    localparam logic [31:0] d_base = 32'h1000_0000;

    logic                  clk;
    logic                  rst_n;
    logic                  icache_req;
    logic [31:0]           icache_addr;
    logic                  icache_addr_ok;
    logic                  icache_data_ok;
    logic [line_width-1:0] icache_rdata;
    logic                  dcache_req;
    l2cache_pkg::d_cmd_t   dcache_cmd;
    logic                  dcache_addr_ok;
    logic                  dcache_data_ok;
    logic [line_width-1:0] dcache_rdata;
    logic                  mem_rd_req;
    logic [31:0]           mem_rd_addr;
    logic                  mem_rd_addr_ok;
    logic                  mem_rd_data_ok;
    logic [line_width-1:0] mem_rd_data;
    logic                  mem_wr_req;
    logic [31:0]           mem_wr_addr;
    logic [line_width-1:0] mem_wr_data;
    logic                  mem_wr_addr_ok;

    logic [line_width-1:0] mem_lines [logic [31:0]];
    logic [line_width-1:0] shadow [logic [31:0]];

    int                  error_count  = 0;
    int                  check_count  = 0;
    int                  test_count   = 0;
    int                  mem_rd_count = 0;
    int                  mem_wr_count = 0;
    logic                i_pending    = 1'b0;
    logic                d_pending    = 1'b0;
    logic [31:0]         i_pend_addr  = '0;
    l2cache_pkg::d_cmd_t d_pend_cmd   = '0;
    string               timeout_what = "";
    event                timed_out;

    l2cache #(.index_width(index_width), .offset_width(offset_width)) dut_i (
        .clk(clk), .rst_n(rst_n),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .icache_addr_ok(icache_addr_ok), .icache_data_ok(icache_data_ok),
        .icache_rdata(icache_rdata),
        .dcache_req(dcache_req), .dcache_cmd(dcache_cmd),
        .dcache_addr_ok(dcache_addr_ok), .dcache_data_ok(dcache_data_ok),
        .dcache_rdata(dcache_rdata),
        .mem_rd_req(mem_rd_req), .mem_rd_addr(mem_rd_addr),
        .mem_rd_addr_ok(mem_rd_addr_ok), .mem_rd_data_ok(mem_rd_data_ok),
        .mem_rd_data(mem_rd_data),
        .mem_wr_req(mem_wr_req), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_addr_ok(mem_wr_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] line_base(input logic [31:0] addr);
        return {addr[31:offset_width+2], {(offset_width+2){1'b0}}};
    endfunction

    // Each word of the initial content hashes its own address
    function automatic logic [line_width-1:0] fill_line(input logic [31:0] base);
        logic [line_width-1:0] line;
        logic [31:0]           a;
        for (int w = 0; w < words; w++) begin
            a = base + 32'(w * 4);
            line[w*32 +: 32] = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
        end
        return line;
    endfunction

    function automatic logic [line_width-1:0] expected_line(input logic [31:0] addr);
        logic [31:0] base;
        base = line_base(addr);
        if (shadow.exists(base)) begin
            return shadow[base];
        end
        return fill_line(base);
    endfunction

    function automatic void apply_write(input l2cache_pkg::d_cmd_t cmd);
        logic [line_width-1:0] line;
        int                    w;
        line = expected_line(cmd.addr);
        w = int'(cmd.addr[offset_width+1:2]);
        for (int b = 0; b < 4; b++) begin
            if (cmd.wstrb[b]) begin
                line[w*32 + b*8 +: 8] = cmd.wdata[b*8 +: 8];
            end
        end
        shadow[line_base(cmd.addr)] = line;
    endfunction

    function automatic logic strobe(input int sel);
        case (sel)
            sel_i_addr: return icache_addr_ok;
            sel_i_data: return icache_data_ok;
            sel_d_addr: return dcache_addr_ok;
            default:    return dcache_data_ok;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [line_width-1:0] actual,
                               input logic [line_width-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // Sample point is 1 ns after the falling edge
    task automatic wait_strobe(input int sel, input string what);
        int waited;
        waited = 0;
        #1;
        while (!strobe(sel)) begin
            if (waited == timeout) begin
                timeout_what = what;
                -> timed_out;
            end
            @(negedge clk);
            #1;
            waited++;
        end
    endtask

    task automatic icache_access(input logic [31:0] addr, output time ok_time,
                                 output time done_time);
        @(negedge clk);
        icache_req  = 1'b1;
        icache_addr = addr;
        wait_strobe(sel_i_addr, "icache_addr_ok");
        ok_time     = $time;
        i_pend_addr = addr;
        i_pending   = 1'b1;
        @(negedge clk);
        icache_req = 1'b0;
        wait_strobe(sel_i_data, "icache_data_ok");
        done_time = $time;
    endtask

    task automatic dcache_access(input logic wr, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] wstrb,
                                 output time ok_time, output time done_time);
        @(negedge clk);
        dcache_req = 1'b1;
        dcache_cmd = '{wr: wr, addr: addr, wdata: wdata, wstrb: wstrb};
        wait_strobe(sel_d_addr, "dcache_addr_ok");
        ok_time    = $time;
        d_pend_cmd = dcache_cmd;
        d_pending  = 1'b1;
        @(negedge clk);
        dcache_req = 1'b0;
        wait_strobe(sel_d_data, "dcache_data_ok");
        done_time = $time;
    endtask

    task automatic end_test(input string name, input int errors_before);
        @(negedge clk);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
    endtask

    // A stuck handshake ends the run
    initial begin : timeout_report
        @(timed_out);
        $display("timeout at %0t: no %s within %0d cycles", $time, timeout_what, timeout);
        $display("Simulation failed");
        $finish;
    end

    // Memory bridge model
    initial begin : memory_model
        int          rd_delay;
        int          wr_delay;
        int          data_wait;
        logic        rd_busy;
        logic        wr_busy;
        logic [31:0] rd_base;
        mem_rd_addr_ok = 1'b0;
        mem_rd_data_ok = 1'b0;
        mem_rd_data    = '0;
        mem_wr_addr_ok = 1'b0;
        rd_delay  = 0;
        wr_delay  = 0;
        data_wait = 0;
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        rd_base   = '0;
        forever begin
            @(negedge clk);
            mem_rd_addr_ok = 1'b0;
            mem_rd_data_ok = 1'b0;
            mem_wr_addr_ok = 1'b0;
            if (data_wait > 0) begin
                data_wait--;
                if (data_wait == 0) begin
                    mem_rd_data_ok = 1'b1;
                    mem_rd_data = mem_lines.exists(rd_base) ? mem_lines[rd_base]
                                                            : fill_line(rd_base);
                end
            end
            if (mem_wr_req && !wr_busy) begin
                wr_busy  = 1'b1;
                wr_delay = $urandom_range(3, 0);
            end
            if (wr_busy) begin
                if (wr_delay == 0) begin
                    mem_wr_addr_ok = 1'b1;
                    wr_busy = 1'b0;
                    mem_wr_count++;
                    check_value("mem_wr_data", mem_wr_data, expected_line(mem_wr_addr));
                    mem_lines[mem_wr_addr] = mem_wr_data;
                end else begin
                    wr_delay--;
                end
            end
            if (mem_rd_req && !rd_busy) begin
                rd_busy  = 1'b1;
                rd_delay = $urandom_range(3, 0);
            end
            if (rd_busy) begin
                if (rd_delay == 0) begin
                    mem_rd_addr_ok = 1'b1;
                    rd_busy   = 1'b0;
                    rd_base   = mem_rd_addr;
                    data_wait = $urandom_range(4, 1);
                    mem_rd_count++;
                end else begin
                    rd_delay--;
                end
            end
        end
    end

    // Compares every response with the reference
    initial begin : response_monitor
        forever begin
            @(negedge clk);
            #1;
            if (icache_data_ok) begin
                if (!i_pending) begin
                    error_count++;
                    $display("error at %0t: icache data_ok without an accepted request", $time);
                end else begin
                    check_value("icache_rdata", icache_rdata, expected_line(i_pend_addr));
                end
                i_pending = 1'b0;
            end
            if (dcache_data_ok) begin
                if (!d_pending) begin
                    error_count++;
                    $display("error at %0t: dcache data_ok without an accepted request", $time);
                end else begin
                    if (d_pend_cmd.wr) begin
                        apply_write(d_pend_cmd);
                    end
                    check_value("dcache_rdata", dcache_rdata, expected_line(d_pend_cmd.addr));
                end
                d_pending = 1'b0;
            end
        end
    end

    initial begin : test_sequence
        int unsigned seed_value;
        int          errors_before;
        int          count_before;
        int          kind;
        time         t0;
        time         t1;
        time         td0;
        time         td1;
        logic [31:0] a;
        logic [31:0] da;
        logic [31:0] db;
        logic [3:0]  strobes [6];
        seed_value  = $urandom(32'h47fcd088);
        strobes     = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b1010, 4'b0000};
        rst_n       = 1'b0;
        icache_req  = 1'b0;
        icache_addr = '0;
        dcache_req  = 1'b0;
        dcache_cmd  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        errors_before = error_count;
        check_value("strobes after reset",
                    line_width'({icache_addr_ok, icache_data_ok, dcache_addr_ok,
                                 dcache_data_ok, mem_rd_req, mem_wr_req}), '0);
        end_test("reset state", errors_before);

        errors_before = error_count;
        icache_access(i_base + 32'h10, t0, t1);
        icache_access(i_base + 32'h14, t0, t1);
        check_value("hit latency", line_width'((t1 - t0) / 10), 1);
        end_test("ifetch miss then hit", errors_before);

        errors_before = error_count;
        for (int k = 0; k < 6; k++) begin
            a = d_base + 32'(k * 4) + 32'((k % 2) * 16);
            dcache_access(1'b1, a, $urandom, strobes[k], t0, t1);
            dcache_access(1'b0, a, '0, 4'b0000, t0, t1);
        end
        end_test("strobed writes", errors_before);

        // Five tags in set 2 against two data ways
        errors_before = error_count;
        count_before  = mem_wr_count;
        for (int t = 0; t < 5; t++) begin
            a = d_base + 32'(t << 6) + 32'h20 + 32'((t % 4) * 4);
            dcache_access(1'b1, a, $urandom, 4'b1111, t0, t1);
        end
        check_value("write-back count", line_width'(mem_wr_count - count_before >= 3), 1);
        for (int t = 0; t < 5; t++) begin
            a = d_base + 32'(t << 6) + 32'h20 + 32'((t % 4) * 4);
            dcache_access(1'b0, a, '0, 4'b0000, t0, t1);
        end
        end_test("dirty eviction", errors_before);

        errors_before = error_count;
        da = d_base + 32'h30;
        db = d_base + 32'h70;
        dcache_access(1'b1, da, 32'hcafe_f00d, 4'b0101, t0, t1);
        dcache_access(1'b1, db, 32'h1234_5678, 4'b1100, t0, t1);
        for (int t = 0; t < 3; t++) begin
            icache_access(i_base + 32'(t << 6) + 32'h30, t0, t1);
        end
        count_before = mem_rd_count;
        dcache_access(1'b0, da, '0, 4'b0000, t0, t1);
        dcache_access(1'b0, db, '0, 4'b0000, t0, t1);
        check_value("memory reads on data hits", line_width'(mem_rd_count - count_before), 0);
        end_test("half separation", errors_before);

        errors_before = error_count;
        fork
            icache_access(i_base + 32'h100, t0, t1);
            dcache_access(1'b0, d_base + 32'h200, '0, 4'b0000, td0, td1);
        join
        check_value("dcache addr_ok first", line_width'(td0 < t0), 1);
        check_value("icache addr_ok after dcache data_ok", line_width'(t0 > td1), 1);
        end_test("arbitration", errors_before);

        errors_before = error_count;
        for (int n = 0; n < 300; n++) begin
            kind = $urandom_range(2, 0);
            a = 32'($urandom_range(5, 0) << 6) + 32'($urandom_range(3, 0) << 4)
                + 32'($urandom_range(3, 0) << 2);
            if (kind == 0) begin
                icache_access(i_base + a, t0, t1);
            end else begin
                dcache_access(kind == 2, d_base + a, $urandom, 4'($urandom), t0, t1);
            end
        end
        end_test("random traffic", errors_before);

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: source/l2cache.sv
`timescale 1ns/1ps

module l2cache #(
    parameter  int index_width  = 2,
    parameter  int offset_width = 2,
    localparam int line_width   = 32 << offset_width
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           icache_req,
    input  logic [l2cache_pkg::ADDR_W-1:0] icache_addr,
    output logic                           icache_addr_ok,
    output logic                           icache_data_ok,
    output logic [line_width-1:0]          icache_rdata,
    input  logic                           dcache_req,
    input  l2cache_pkg::d_cmd_t            dcache_cmd,
    output logic                           dcache_addr_ok,
    output logic                           dcache_data_ok,
    output logic [line_width-1:0]          dcache_rdata,
    output logic                           mem_rd_req,
    output logic [l2cache_pkg::ADDR_W-1:0] mem_rd_addr,
    input  logic                           mem_rd_addr_ok,
    input  logic                           mem_rd_data_ok,
    input  logic [line_width-1:0]          mem_rd_data,
    output logic                           mem_wr_req,
    output logic [l2cache_pkg::ADDR_W-1:0] mem_wr_addr,
    output logic [line_width-1:0]          mem_wr_data,
    input  logic                           mem_wr_addr_ok
);

    localparam int tag_width = 30 - index_width - offset_width;
    localparam int tag_lsb   = index_width + offset_width + 2;

    l2cache_pkg::req_src_e          cur_src;
    logic [l2cache_pkg::ADDR_W-1:0] cur_addr;
    l2cache_pkg::l2_req_t           req;
    logic                           accept;
    logic [index_width-1:0]         req_index;
    logic [index_width-1:0]         rd_index;
    logic [tag_width-1:0]           req_tag;
    logic [tag_width-1:0]           victim_tag;
    logic [offset_width-1:0]        word_sel;
    logic [3:0]                     wr_strb;
    logic [3:0]                     hit;
    logic [3:0]                     valid;
    logic [3:0]                     way_we;
    logic [1:0]                     victim_i;
    logic [1:0]                     victim_d;
    logic [1:0]                     victim_way;
    logic [1:0]                     touch_way;
    logic [1:0]                     hit_way;
    logic                           victim_dirty;
    logic                           refill;
    logic                           tag_we;
    logic                           set_dirty;
    logic                           wr_dirty;
    logic                           touch;
    logic                           use_mem_line;
    logic [3:0][line_width-1:0]     rd_lines;
    logic [line_width-1:0]          resp_line;

    assign req_index = req.addr[tag_lsb-1:offset_width+2];
    assign req_tag   = req.addr[l2cache_pkg::ADDR_W-1:tag_lsb];
    assign word_sel  = req.addr[offset_width+1:2];

    // New request reads the arrays at the accept edge
    assign rd_index = accept ? cur_addr[tag_lsb-1:offset_width+2] : req_index;
    assign wr_strb  = (req.src == l2cache_pkg::REQ_DWRITE) ? req.wstrb : 4'b0000;

    always_comb begin
        resp_line = use_mem_line ? mem_rd_data : rd_lines[hit_way];
        resp_line[word_sel*32 +: 32] =
            l2cache_pkg::merge_word(resp_line[word_sel*32 +: 32], req.wdata, wr_strb);
    end

    assign icache_rdata = resp_line;
    assign dcache_rdata = resp_line;

    assign mem_rd_addr = {req.addr[l2cache_pkg::ADDR_W-1:offset_width+2], {(offset_width+2){1'b0}}};
    assign mem_wr_addr = {victim_tag, req_index, {(offset_width+2){1'b0}}};
    assign mem_wr_data = rd_lines[victim_way];

    l2cache_req_buf req_buf_i (
        .clk(clk), .rst_n(rst_n),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .dcache_req(dcache_req), .dcache_cmd(dcache_cmd),
        .accept(accept), .cur_src(cur_src), .cur_addr(cur_addr), .req(req)
    );

    l2cache_tagv #(.index_width(index_width), .offset_width(offset_width)) tagv_i (
        .clk(clk), .rst_n(rst_n),
        .rd_index(rd_index), .cmp_tag(req_tag),
        .half(req.src != l2cache_pkg::REQ_IFETCH),
        .hit(hit), .valid(valid),
        .victim_way(victim_way), .victim_tag(victim_tag), .victim_dirty(victim_dirty),
        .we(tag_we), .wr_index(req_index), .wr_tag(req_tag),
        .wr_dirty(wr_dirty), .set_dirty(set_dirty)
    );

    l2cache_data #(.index_width(index_width), .offset_width(offset_width)) data_i (
        .clk(clk), .rd_index(rd_index), .rd_lines(rd_lines),
        .wr_index(req_index), .way_we(way_we), .refill(refill),
        .refill_line(mem_rd_data), .word_sel(word_sel),
        .wdata(req.wdata), .wstrb(wr_strb)
    );

    l2cache_plru #(.index_width(index_width)) plru_i (
        .clk(clk), .rst_n(rst_n), .index(req_index), .valid(valid),
        .touch(touch), .touch_way(touch_way),
        .victim_i(victim_i), .victim_d(victim_d)
    );

    l2cache_fsm fsm_i (
        .clk(clk), .rst_n(rst_n),
        .cur_src(cur_src), .req(req), .hit(hit), .valid(valid),
        .victim_i(victim_i), .victim_d(victim_d), .victim_dirty(victim_dirty),
        .accept(accept),
        .icache_addr_ok(icache_addr_ok), .icache_data_ok(icache_data_ok),
        .dcache_addr_ok(dcache_addr_ok), .dcache_data_ok(dcache_data_ok),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_addr_ok(mem_rd_addr_ok), .mem_wr_addr_ok(mem_wr_addr_ok),
        .mem_rd_data_ok(mem_rd_data_ok),
        .way_we(way_we), .refill(refill), .tag_we(tag_we),
        .set_dirty(set_dirty), .wr_dirty(wr_dirty),
        .touch(touch), .touch_way(touch_way), .victim_way(victim_way),
        .use_mem_line(use_mem_line), .hit_way(hit_way)
    );

endmodule

// File: source/l2cache_fsm.sv
`timescale 1ns/1ps

module l2cache_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  l2cache_pkg::req_src_e cur_src,
    input  l2cache_pkg::l2_req_t  req,
    input  logic [3:0]            hit,
    input  logic [3:0]            valid,
    input  logic [1:0]            victim_i,
    input  logic [1:0]            victim_d,
    input  logic                  victim_dirty,
    output logic                  accept,
    output logic                  icache_addr_ok,
    output logic                  icache_data_ok,
    output logic                  dcache_addr_ok,
    output logic                  dcache_data_ok,
    output logic                  mem_rd_req,
    output logic                  mem_wr_req,
    input  logic                  mem_rd_addr_ok,
    input  logic                  mem_wr_addr_ok,
    input  logic                  mem_rd_data_ok,
    output logic [3:0]            way_we,
    output logic                  refill,
    output logic                  tag_we,
    output logic                  set_dirty,
    output logic                  wr_dirty,
    output logic                  touch,
    output logic [1:0]            touch_way,
    output logic [1:0]            victim_way,
    output logic                  use_mem_line,
    output logic [1:0]            hit_way
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        REFILL_WAIT
    } state_e;

    state_e     state;
    state_e     state_next;
    logic [1:0] victim_q;
    logic [1:0] miss_way;
    logic       is_hit;
    logic       is_data;
    logic       is_write;
    logic       respond;

    assign is_hit   = |hit;
    assign is_data  = req.src != l2cache_pkg::REQ_IFETCH;
    assign is_write = req.src == l2cache_pkg::REQ_DWRITE;
    assign miss_way = is_data ? victim_d : victim_i;

    always_comb begin
        if (hit[1]) begin
            hit_way = 2'd1;
        end else if (hit[2]) begin
            hit_way = 2'd2;
        end else if (hit[3]) begin
            hit_way = 2'd3;
        end else begin
            hit_way = 2'd0;
        end
    end

    // Way under inspection in LOOKUP, the locked victim after a miss
    assign victim_way = (state == LOOKUP) ? (is_hit ? hit_way : miss_way) : victim_q;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (is_hit) begin
                    state_next = IDLE;
                end else if (valid[miss_way] && victim_dirty) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_wr_addr_ok) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_rd_addr_ok) begin
                    state_next = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rd_data_ok) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            victim_q <= 2'd0;
        end else begin
            state <= state_next;
            if (state == LOOKUP && !is_hit) begin
                victim_q <= miss_way;
            end
        end
    end

    assign accept         = (state == IDLE) && (cur_src != l2cache_pkg::REQ_NONE);
    assign icache_addr_ok = accept && (cur_src == l2cache_pkg::REQ_IFETCH);
    assign dcache_addr_ok = accept && (cur_src != l2cache_pkg::REQ_IFETCH);

    assign respond = ((state == LOOKUP) && is_hit) || ((state == REFILL_WAIT) && mem_rd_data_ok);
    assign icache_data_ok = respond && !is_data;
    assign dcache_data_ok = respond && is_data;

    assign mem_wr_req   = state == WRITEBACK;
    assign mem_rd_req   = state == REFILL;
    assign use_mem_line = state == REFILL_WAIT;
    assign refill       = state == REFILL_WAIT;

    // Line arrives, allocate it
    assign tag_we    = (state == REFILL_WAIT) && mem_rd_data_ok;
    assign wr_dirty  = is_write;
    assign set_dirty = (state == LOOKUP) && is_hit && is_write;
    assign way_we    = (set_dirty || tag_we) ? (4'b0001 << victim_way) : 4'b0000;

    assign touch     = respond;
    assign touch_way = victim_way;

endmodule

// File: source/l2cache_plru.sv
`timescale 1ns/1ps

module l2cache_plru #(
    parameter int index_width = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] index,
    input  logic [3:0]             valid,
    input  logic                   touch,
    input  logic [1:0]             touch_way,
    output logic [1:0]             victim_i,
    output logic [1:0]             victim_d
);

    localparam int sets = 1 << index_width;

    // One bit per half, names the way not used last
    logic [sets-1:0][1:0] nru_bits;

    function automatic logic pick_way(input logic [1:0] half_valid, input logic nru);
        if (!half_valid[0]) begin
            return 1'b0;
        end else if (!half_valid[1]) begin
            return 1'b1;
        end
        return nru;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nru_bits <= '0;
        end else if (touch) begin
            nru_bits[index][touch_way[1]] <= ~touch_way[0];
        end
    end

    assign victim_i = {1'b0, pick_way(valid[1:0], nru_bits[index][0])};
    assign victim_d = {1'b1, pick_way(valid[3:2], nru_bits[index][1])};

endmodule

// File: source/l2cache_data.sv
`timescale 1ns/1ps

module l2cache_data #(
    parameter  int index_width  = 2,
    parameter  int offset_width = 2,
    localparam int line_width   = 32 << offset_width
) (
    input  logic                        clk,
    input  logic [index_width-1:0]      rd_index,
    output logic [3:0][line_width-1:0]  rd_lines,
    input  logic [index_width-1:0]      wr_index,
    input  logic [3:0]                  way_we,
    input  logic                        refill,
    input  logic [line_width-1:0]       refill_line,
    input  logic [offset_width-1:0]     word_sel,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb
);

    localparam int sets = 1 << index_width;

    logic [line_width-1:0]       lines_mem [4][sets];
    logic [3:0][line_width-1:0]  wr_lines;

    // Refill starts from the memory line, a hit write from the stored one
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            wr_lines[w] = refill ? refill_line : rd_lines[w];
            wr_lines[w][word_sel*32 +: 32] =
                l2cache_pkg::merge_word(wr_lines[w][word_sel*32 +: 32], wdata, wstrb);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 4; w++) begin
            rd_lines[w] <= lines_mem[w][rd_index];
            if (way_we[w]) begin
                lines_mem[w][wr_index] <= wr_lines[w];
            end
        end
    end

endmodule

// File: source/l2cache_tagv.sv
`timescale 1ns/1ps

module l2cache_tagv #(
    parameter  int index_width  = 2,
    parameter  int offset_width = 2,
    localparam int tag_width    = 30 - index_width - offset_width
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [index_width-1:0] rd_index,
    input  logic [tag_width-1:0]   cmp_tag,
    input  logic                   half,
    output logic [3:0]             hit,
    output logic [3:0]             valid,
    input  logic [1:0]             victim_way,
    output logic [tag_width-1:0]   victim_tag,
    output logic                   victim_dirty,
    input  logic                   we,
    input  logic [index_width-1:0] wr_index,
    input  logic [tag_width-1:0]   wr_tag,
    input  logic                   wr_dirty,
    input  logic                   set_dirty
);

    localparam int sets = 1 << index_width;

    logic [tag_width-1:0]   tag_mem [4][sets];
    logic [tag_width-1:0]   tag_q [4];
    logic [index_width-1:0] index_q;
    logic [sets-1:0][3:0]   valid_bits;
    logic [sets-1:0][3:0]   dirty_bits;

    // Registered tag read, valid and dirty follow the same index
    always_ff @(posedge clk) begin
        index_q <= rd_index;
        for (int w = 0; w < 4; w++) begin
            tag_q[w] <= tag_mem[w][rd_index];
        end
        if (we) begin
            tag_mem[victim_way][wr_index] <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[wr_index][victim_way] <= 1'b1;
            dirty_bits[wr_index][victim_way] <= wr_dirty;
        end else if (set_dirty) begin
            dirty_bits[wr_index][victim_way] <= 1'b1;
        end
    end

    assign valid = valid_bits[index_q];

    // Ways 0 and 1 serve fetches, ways 2 and 3 data
    always_comb begin
        for (int w = 0; w < 4; w++) begin
            hit[w] = valid[w] && (tag_q[w] == cmp_tag) && ((w >= 2) == half);
        end
    end

    assign victim_tag   = tag_q[victim_way];
    assign victim_dirty = dirty_bits[index_q][victim_way];

endmodule

// File: source/l2cache_req_buf.sv
`timescale 1ns/1ps

module l2cache_req_buf (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           icache_req,
    input  logic [l2cache_pkg::ADDR_W-1:0] icache_addr,
    input  logic                           dcache_req,
    input  l2cache_pkg::d_cmd_t            dcache_cmd,
    input  logic                           accept,
    output l2cache_pkg::req_src_e          cur_src,
    output logic [l2cache_pkg::ADDR_W-1:0] cur_addr,
    output l2cache_pkg::l2_req_t           req
);

    l2cache_pkg::req_src_e          src_q;
    logic [l2cache_pkg::ADDR_W-1:0] addr_q;
    logic [31:0]                    wdata_q;
    logic [3:0]                     wstrb_q;

    // Data cache wins a same-cycle tie
    always_comb begin
        if (dcache_req) begin
            cur_src = dcache_cmd.wr ? l2cache_pkg::REQ_DWRITE : l2cache_pkg::REQ_DREAD;
        end else if (icache_req) begin
            cur_src = l2cache_pkg::REQ_IFETCH;
        end else begin
            cur_src = l2cache_pkg::REQ_NONE;
        end
    end

    assign cur_addr = dcache_req ? dcache_cmd.addr : icache_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            src_q <= l2cache_pkg::REQ_NONE;
        end else if (accept) begin
            src_q <= cur_src;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= cur_addr;
            wdata_q <= dcache_cmd.wdata;
            wstrb_q <= dcache_cmd.wstrb;
        end
    end

    assign req = '{src: src_q, addr: addr_q, wdata: wdata_q, wstrb: wstrb_q};

endmodule

// File: source/l2cache_pkg.sv
package l2cache_pkg;

    localparam int ADDR_W = 32;

    // Owner of the request in flight
    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_IFETCH,
        REQ_DREAD,
        REQ_DWRITE
    } req_src_e;

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
    } d_cmd_t;

    typedef struct packed {
        req_src_e          src;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
    } l2_req_t;

    // Byte-strobed merge of one word
    function automatic logic [31:0] merge_word(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage
